//--- hw/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Instruction memory depth in 32-bit words
`define MIPS_IMEM_DEPTH 64

// Data memory depth in 32-bit words
`define MIPS_DMEM_DEPTH 64

// PC counts words, so its width covers the instruction memory
`define MIPS_PC_W 6

`endif

//--- hw/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // Control carried from ID/EX onwards, all zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    reg_dst_rd;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- hw/mips_ifs.sv
`timescale 1ns/1ps

// ID/EX pipeline register contents
interface id_ex_if import mips_pkg::*; ();

    ctrl_t     ctrl;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;                   // Sign extended
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    modport stage_out (
        output ctrl, rs_val, rt_val, imm, rs, rt, rd
    );

    modport stage_in (
        input ctrl, rs_val, rt_val, imm, rs, rt, rd
    );

endinterface

// EX/MEM pipeline register contents
interface ex_mem_if import mips_pkg::*; ();

    ctrl_t     ctrl;
    word_t     alu_res;               // Also the data memory address
    word_t     store_data;
    reg_addr_t dst;

    modport stage_out (
        output ctrl, alu_res, store_data, dst
    );

    modport stage_in (
        input ctrl, alu_res, store_data, dst
    );

    // Forwarding and hazard taps
    modport monitor (
        input ctrl, alu_res, dst
    );

endinterface

//--- hw/instruction_fetch.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module instruction_fetch import mips_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_freeze,
    input  logic                  i_hold,
    input  logic                  i_flush,
    input  logic                  i_taken,
    input  logic [`MIPS_PC_W-1:0] i_target,
    input  logic                  i_imem_we,
    input  logic [`MIPS_PC_W-1:0] i_imem_addr,
    input  word_t                 i_imem_data,
    output word_t                 o_instr,
    output logic [`MIPS_PC_W-1:0] o_pc_next
);

    logic [`MIPS_PC_W-1:0] pc_q;
    logic [`MIPS_PC_W-1:0] pc_inc;
    word_t                 imem [`MIPS_IMEM_DEPTH];
    word_t                 fetched;

    assign pc_inc  = pc_q + 1'b1;
    assign fetched = imem[pc_q];

    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;       // Load port, works even when frozen
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= '0;
        end else if (!i_freeze) begin
            if (i_taken) begin
                pc_q <= i_target;
            end else if (!i_hold) begin
                pc_q <= pc_inc;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_instr   <= '0;
            o_pc_next <= '0;
        end else if (!i_freeze) begin
            if (i_flush) begin
                o_instr <= '0;                      // sll $0 acts as a bubble
            end else if (!i_hold) begin
                o_instr   <= fetched;
                o_pc_next <= pc_inc;
            end
        end
    end

    // Decode only resolves a branch once its operands are ready
    a_taken_not_held: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_taken && i_hold));

endmodule

//--- hw/instruction_decode.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module instruction_decode import mips_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_freeze,
    input  word_t                 i_instr,
    input  logic [`MIPS_PC_W-1:0] i_pc_next,
    input  logic                  i_wb_en,
    input  reg_addr_t             i_wb_addr,
    input  word_t                 i_wb_data,
    ex_mem_if.monitor             em,
    input  reg_addr_t             i_dbg_reg_addr,
    output logic                  o_hold,
    output logic                  o_flush,
    output logic                  o_taken,
    output logic [`MIPS_PC_W-1:0] o_target,
    output word_t                 o_dbg_reg_data,
    id_ex_if.stage_out            ie
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs, rt, rd;
    word_t     imm;
    word_t     regs [32];
    word_t     rs_val, rt_val;
    word_t     br_a, br_b;
    ctrl_t     ctrl_d;
    logic      is_beq, is_bne, is_jump, uses_rt;
    logic      load_use, branch_ex, branch_mem, hold;
    reg_addr_t ex_dst;
    ctrl_t     ctrl_q;
    reg_addr_t rs_q, rt_q, rd_q;
    word_t     rs_val_q, rt_val_q, imm_q;

    assign opcode = opcode_e'(i_instr[31:26]);
    assign funct  = funct_e'(i_instr[5:0]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign imm    = {{16{i_instr[15]}}, i_instr[15:0]};

    // Read with same-cycle writeback bypass
    function automatic word_t rf_read(input reg_addr_t a);
        if (a == '0) return '0;
        if (i_wb_en && i_wb_addr == a) return i_wb_data;
        return regs[a];
    endfunction

    always_ff @(posedge i_clk) begin
        if (!i_freeze && i_wb_en && i_wb_addr != '0) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    always_comb begin
        rs_val         = rf_read(rs);
        rt_val         = rf_read(rt);
        o_dbg_reg_data = rf_read(i_dbg_reg_addr);
    end

    always_comb begin
        ctrl_d = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl_d.reg_write  = 1'b1;
                ctrl_d.reg_dst_rd = 1'b1;
                case (funct)
                    F_ADD:   ctrl_d.alu_op = ALU_ADD;
                    F_SUB:   ctrl_d.alu_op = ALU_SUB;
                    F_AND:   ctrl_d.alu_op = ALU_AND;
                    F_OR:    ctrl_d.alu_op = ALU_OR;
                    F_SLT:   ctrl_d.alu_op = ALU_SLT;
                    default: ctrl_d.reg_write = 1'b0;   // Unsupported funct is a nop
                endcase
            end
            OP_ADDI: begin
                ctrl_d.reg_write   = 1'b1;
                ctrl_d.alu_src_imm = 1'b1;
            end
            OP_LW: begin
                ctrl_d.reg_write   = 1'b1;
                ctrl_d.mem_read    = 1'b1;
                ctrl_d.mem_to_reg  = 1'b1;
                ctrl_d.alu_src_imm = 1'b1;
            end
            OP_SW: begin
                ctrl_d.mem_write   = 1'b1;
                ctrl_d.alu_src_imm = 1'b1;
            end
            default: ctrl_d = '0;                       // Branches and jumps finish here
        endcase
    end

    assign is_beq  = (opcode == OP_BEQ);
    assign is_bne  = (opcode == OP_BNE);
    assign is_jump = (opcode == OP_J);
    assign uses_rt = (opcode == OP_RTYPE) || (opcode == OP_SW) || is_beq || is_bne;

    // Branch compare forwarding, writeback is covered by rf_read
    assign br_a = (em.ctrl.reg_write && em.dst != '0 && em.dst == rs) ? em.alu_res : rs_val;
    assign br_b = (em.ctrl.reg_write && em.dst != '0 && em.dst == rt) ? em.alu_res : rt_val;

    assign ex_dst     = ctrl_q.reg_dst_rd ? rd_q : rt_q;
    assign load_use   = ctrl_q.mem_read && rt_q != '0 &&
                        ((!is_jump && rt_q == rs) || (uses_rt && rt_q == rt));
    assign branch_ex  = (is_beq || is_bne) && ctrl_q.reg_write && ex_dst != '0 &&
                        (ex_dst == rs || ex_dst == rt);
    assign branch_mem = (is_beq || is_bne) && em.ctrl.mem_read && em.dst != '0 &&
                        (em.dst == rs || em.dst == rt);
    assign hold       = load_use || branch_ex || branch_mem;

    assign o_hold   = hold;
    assign o_taken  = !hold && ((is_beq && br_a == br_b) || (is_bne && br_a != br_b) || is_jump);
    assign o_flush  = o_taken;
    assign o_target = is_jump ? i_instr[`MIPS_PC_W-1:0] : i_pc_next + imm[`MIPS_PC_W-1:0];

    // ID/EX register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ctrl_q <= '0;
            rs_q   <= '0;
            rt_q   <= '0;
            rd_q   <= '0;
        end else if (!i_freeze) begin
            ctrl_q <= hold ? '0 : ctrl_d;               // Stall inserts a bubble
            rs_q   <= rs;
            rt_q   <= rt;
            rd_q   <= rd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_freeze) begin
            rs_val_q <= rs_val;
            rt_val_q <= rt_val;
            imm_q    <= imm;
        end
    end

    assign ie.ctrl   = ctrl_q;
    assign ie.rs_val = rs_val_q;
    assign ie.rt_val = rt_val_q;
    assign ie.imm    = imm_q;
    assign ie.rs     = rs_q;
    assign ie.rt     = rt_q;
    assign ie.rd     = rd_q;

    // Stall bubble stays inert on its way into EX/MEM
    a_bubble_is_inert: assert property (@(posedge i_clk) disable iff (i_rst)
        (hold && !i_freeze) ##1 !i_freeze |=> (!em.ctrl.reg_write && !em.ctrl.mem_write));

endmodule

//--- hw/execution.sv
`timescale 1ns/1ps

module execution import mips_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_freeze,
    input  logic       i_wb_en,
    input  reg_addr_t  i_wb_addr,
    input  word_t      i_wb_data,
    id_ex_if.stage_in  ie,
    ex_mem_if.monitor  em_fwd,
    ex_mem_if.stage_out em
);

    logic      em_ok, wb_ok;
    word_t     op_a, op_rt, op_b;
    word_t     alu_res;
    reg_addr_t dst;

    // Register 0 is never forwarded
    assign em_ok = em_fwd.ctrl.reg_write && em_fwd.dst != '0;
    assign wb_ok = i_wb_en && i_wb_addr != '0;

    // EX/MEM wins over writeback since it is younger
    assign op_a  = (em_ok && em_fwd.dst == ie.rs) ? em_fwd.alu_res :
                   (wb_ok && i_wb_addr == ie.rs)  ? i_wb_data      : ie.rs_val;
    assign op_rt = (em_ok && em_fwd.dst == ie.rt) ? em_fwd.alu_res :
                   (wb_ok && i_wb_addr == ie.rt)  ? i_wb_data      : ie.rt_val;
    assign op_b  = ie.ctrl.alu_src_imm ? ie.imm : op_rt;

    always_comb begin
        case (ie.ctrl.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_res = '0;
        endcase
    end

    assign dst = ie.ctrl.reg_dst_rd ? ie.rd : ie.rt;

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            em.ctrl <= '0;
            em.dst  <= '0;
        end else if (!i_freeze) begin
            em.ctrl <= ie.ctrl;
            em.dst  <= dst;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_freeze) begin
            em.alu_res    <= alu_res;
            em.store_data <= op_rt;                 // Forwarded rt for sw
        end
    end

    // Decode must only hand over ALU codes the datapath knows
    a_alu_op_legal: assert property (@(posedge i_clk) disable iff (i_rst)
        ie.ctrl.reg_write |-> ie.ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND,
                                                      ALU_OR, ALU_SLT});

endmodule

//--- hw/data_memory.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module data_memory import mips_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_freeze,
    input  logic [5:0] i_dbg_mem_addr,
    ex_mem_if.stage_in em,
    output logic       o_wb_en,
    output reg_addr_t  o_wb_addr,
    output word_t      o_wb_data,
    output word_t      o_dbg_mem_data
);

    localparam int DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

    word_t                dmem [`MIPS_DMEM_DEPTH];
    logic [DMEM_AW-1:0]   addr;
    logic                 reg_write_q;
    logic                 mem_to_reg_q;
    reg_addr_t            dst_q;
    word_t                res_q;
    word_t                rdata_q;

    assign addr           = em.alu_res[DMEM_AW-1:0];   // Word index
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    always_ff @(posedge i_clk) begin
        if (!i_freeze && em.ctrl.mem_write) begin
            dmem[addr] <= em.store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
            dst_q        <= '0;
        end else if (!i_freeze) begin
            reg_write_q  <= em.ctrl.reg_write;
            mem_to_reg_q <= em.ctrl.mem_to_reg;
            dst_q        <= em.dst;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_freeze) begin
            res_q <= em.alu_res;
            if (em.ctrl.mem_read) rdata_q <= dmem[addr];
        end
    end

    assign o_wb_en   = reg_write_q;
    assign o_wb_addr = dst_q;
    assign o_wb_data = mem_to_reg_q ? rdata_q : res_q;

endmodule

//--- hw/mips.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips import mips_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_stall,
    input  logic       i_imem_we,
    input  logic [5:0] i_imem_addr,
    input  word_t      i_imem_data,
    input  reg_addr_t  i_dbg_reg_addr,
    input  logic [5:0] i_dbg_mem_addr,
    output word_t      o_dbg_reg_data,
    output word_t      o_dbg_mem_data
);

    logic                  freeze;
    word_t                 instr;
    logic [`MIPS_PC_W-1:0] pc_next;
    logic [`MIPS_PC_W-1:0] target;
    logic                  hold, flush, taken;
    logic                  wb_en;
    reg_addr_t             wb_addr;
    word_t                 wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    assign freeze = i_stall | i_imem_we;               // Whole pipeline holds

    instruction_fetch u_if (
        .i_clk(i_clk), .i_rst(i_rst), .i_freeze(freeze),
        .i_hold(hold), .i_flush(flush), .i_taken(taken), .i_target(target),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_instr(instr), .o_pc_next(pc_next)
    );

    instruction_decode u_id (
        .i_clk(i_clk), .i_rst(i_rst), .i_freeze(freeze),
        .i_instr(instr), .i_pc_next(pc_next),
        .i_wb_en(wb_en), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
        .em(ex_mem.monitor), .i_dbg_reg_addr(i_dbg_reg_addr),
        .o_hold(hold), .o_flush(flush), .o_taken(taken), .o_target(target),
        .o_dbg_reg_data(o_dbg_reg_data), .ie(id_ex.stage_out)
    );

    execution u_ex (
        .i_clk(i_clk), .i_rst(i_rst), .i_freeze(freeze),
        .i_wb_en(wb_en), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
        .ie(id_ex.stage_in), .em_fwd(ex_mem.monitor), .em(ex_mem.stage_out)
    );

    data_memory u_mem (
        .i_clk(i_clk), .i_rst(i_rst), .i_freeze(freeze),
        .i_dbg_mem_addr(i_dbg_mem_addr), .em(ex_mem.stage_in),
        .o_wb_en(wb_en), .o_wb_addr(wb_addr), .o_wb_data(wb_data),
        .o_dbg_mem_data(o_dbg_mem_data)
    );

endmodule

//--- sim/mips_tb.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_tb import mips_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int PROG_MAX    = 32;                // Longest program is the register clear
    localparam int TEST_CYCLES = PROG_MAX + 4 * PROG_MAX + 20 + 32 + `MIPS_DMEM_DEPTH;
    localparam int WD_CYCLES   = 6 * TEST_CYCLES + 10 * 8 + 50;

    logic       clk = 1'b0;
    logic       rst;
    logic       stall;
    logic       imem_we;
    logic [5:0] imem_addr;
    word_t      imem_data;
    reg_addr_t  dbg_reg_addr;
    logic [5:0] dbg_mem_addr;
    word_t      dbg_reg_data;
    word_t      dbg_mem_data;

    word_t       prog [$];
    word_t       m_regs [32];                       // Expected register file
    word_t       m_mem [`MIPS_DMEM_DEPTH];
    logic        m_valid [`MIPS_DMEM_DEPTH];        // Words stored by some program
    int          skip_count;                        // Emitted words on a skipped path
    logic [15:0] lfsr_q;
    int          errors;
    int          checks;

    mips DUT (
        .i_clk(clk), .i_rst(rst), .i_stall(stall),
        .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
        .i_dbg_reg_addr(dbg_reg_addr), .i_dbg_mem_addr(dbg_mem_addr),
        .o_dbg_reg_data(dbg_reg_data), .o_dbg_mem_data(dbg_mem_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // 16-bit Galois LFSR
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    function automatic word_t sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Returns 0 when the word lies on a path the program never executes
    function automatic bit emit(input word_t w);
        prog.push_back(w);
        if (skip_count > 0) begin
            skip_count--;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic set_reg(input reg_addr_t a, input word_t v);
        if (a != '0) m_regs[a] = v;                 // $0 stays zero
    endtask

    task automatic op_r(input funct_e f, input reg_addr_t rd, input reg_addr_t rs,
                        input reg_addr_t rt);
        word_t a, b, r;
        a = m_regs[rs];
        b = m_regs[rt];
        case (f)
            F_ADD:   r = a + b;
            F_SUB:   r = a - b;
            F_AND:   r = a & b;
            F_OR:    r = a | b;
            default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        if (emit({OP_RTYPE, rs, rt, rd, 5'd0, f})) set_reg(rd, r);
    endtask

    task automatic op_addi(input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm);
        if (emit({OP_ADDI, rs, rt, imm})) set_reg(rt, m_regs[rs] + sext(imm));
    endtask

    task automatic op_lw(input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm);
        word_t addr;
        addr = m_regs[rs] + sext(imm);
        if (emit({OP_LW, rs, rt, imm})) set_reg(rt, m_mem[addr[5:0]]);
    endtask

    task automatic op_sw(input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm);
        word_t addr;
        addr = m_regs[rs] + sext(imm);
        if (emit({OP_SW, rs, rt, imm})) begin
            m_mem[addr[5:0]]   = m_regs[rt];
            m_valid[addr[5:0]] = 1'b1;
        end
    endtask

    task automatic op_branch(input opcode_e op, input reg_addr_t rs, input reg_addr_t rt,
                             input logic [15:0] off);
        bit taken;
        taken = (m_regs[rs] == m_regs[rt]) == (op == OP_BEQ);
        if (emit({op, rs, rt, off}) && taken) skip_count = off;
    endtask

    task automatic op_jump_over(input int n);
        int target;
        target = prog.size() + 1 + n;
        if (emit({OP_J, 26'(target)})) skip_count = n;
    endtask

    task automatic check_reg(input string name, input reg_addr_t a, input word_t exp);
        @(posedge clk);
        dbg_reg_addr <= a;
        @(negedge clk);
        checks++;
        if (dbg_reg_data !== exp) begin
            errors++;
            $display("FAIL %s: r%0d expected %h actual %h", name, a, exp, dbg_reg_data);
        end
    endtask

    task automatic check_mem(input string name, input logic [5:0] a, input word_t exp);
        @(posedge clk);
        dbg_mem_addr <= a;
        @(negedge clk);
        checks++;
        if (dbg_mem_data !== exp) begin
            errors++;
            $display("FAIL %s: mem[%0d] expected %h actual %h", name, a, exp, dbg_mem_data);
        end
    endtask

    task automatic check_state(input string name);
        for (int r = 0; r < 32; r++) begin
            check_reg(name, reg_addr_t'(r), m_regs[r]);
        end
        for (int a = 0; a < `MIPS_DMEM_DEPTH; a++) begin
            if (m_valid[a]) check_mem(name, 6'(a), m_mem[a]);
        end
    endtask

    // Load under reset, run for the cycle bound, then compare with the model
    task automatic run_program(input string name, input bit with_stalls);
        int n, bound, c, k;
        void'(emit({OP_J, 26'(prog.size())}));      // Jump to itself ends the program
        n     = prog.size();
        bound = 4 * n + 20;
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < ((n > 16) ? n : 16); i++) begin
            @(posedge clk);
            imem_we   <= (i < n);
            imem_addr <= 6'(i);
            imem_data <= (i < n) ? prog[i] : '0;
        end
        @(posedge clk);
        rst     <= 1'b0;
        imem_we <= 1'b0;
        c = 0;
        k = 0;
        while (c < bound) begin
            @(posedge clk);
            if (with_stalls && k < 10 && c == 3 + 4 * k) begin
                stall <= 1'b1;
                repeat (1 + rand_bits(3)) @(posedge clk);
                stall <= 1'b0;
                k++;
            end
            c++;
        end
        check_state(name);
    endtask

    task automatic clear_regs();
        prog.delete();
        skip_count = 0;
        for (int r = 1; r < 32; r++) begin
            op_addi(reg_addr_t'(r), 0, 16'h0000);
        end
        run_program("clear", 1'b0);
    endtask

    task automatic test_arith();
        prog.delete();
        op_addi(1, 0, 16'(rand_bits(16)));
        op_addi(2, 0, 16'(rand_bits(16)));
        op_r(F_ADD, 3, 1, 2);                       // r1 from writeback, r2 from EX/MEM
        op_r(F_SUB, 4, 3, 1);
        op_r(F_AND, 5, 4, 3);
        op_r(F_OR, 6, 5, 2);
        op_r(F_SLT, 7, 6, 4);
        op_r(F_SLT, 8, 4, 6);
        op_addi(9, 7, 16'(rand_bits(16)));
        op_r(F_ADD, 10, 9, 8);
        run_program("arith", 1'b0);
    endtask

    task automatic test_memory();
        prog.delete();
        op_addi(11, 0, 16'd5);
        op_sw(3, 11, 16'd0);
        op_sw(10, 11, 16'd2);
        op_r(F_ADD, 12, 3, 10);
        op_sw(12, 11, 16'd3);
        op_lw(13, 11, 16'd0);
        op_lw(14, 11, 16'd2);
        op_r(F_ADD, 15, 14, 13);                    // Load-use on r14
        op_lw(16, 11, 16'd3);
        op_sw(16, 11, 16'd4);                       // Load-use through store data
        run_program("memory", 1'b0);
    endtask

    task automatic test_branch();
        prog.delete();
        op_addi(17, 0, 16'd7);
        op_addi(18, 0, 16'd7);
        op_branch(OP_BEQ, 17, 18, 16'd1);           // Taken, r18 still in execute
        op_addi(19, 0, 16'd1);
        op_addi(20, 0, 16'd2);
        op_branch(OP_BNE, 17, 18, 16'd1);
        op_addi(21, 0, 16'd3);
        op_addi(22, 0, 16'd9);
        op_branch(OP_BNE, 22, 17, 16'd1);
        op_addi(23, 0, 16'd4);
        op_branch(OP_BEQ, 22, 17, 16'd1);
        op_addi(24, 0, 16'd5);
        op_addi(25, 0, 16'h0055);
        op_sw(25, 0, 16'd10);
        op_lw(26, 0, 16'd10);
        op_branch(OP_BEQ, 26, 25, 16'd1);           // Depends on a load, two bubbles
        op_addi(27, 0, 16'd6);
        op_addi(28, 0, 16'd8);
        run_program("branch", 1'b0);
    endtask

    task automatic test_jump();
        prog.delete();
        op_addi(29, 0, 16'h0011);
        op_jump_over(3);
        op_addi(30, 0, 16'd1);
        op_addi(31, 0, 16'd2);
        op_r(F_ADD, 29, 0, 0);
        op_r(F_ADD, 1, 29, 29);
        run_program("jump", 1'b0);
    endtask

    task automatic test_reg0_stall();
        prog.delete();
        op_addi(0, 0, 16'd123);
        op_r(F_ADD, 0, 1, 1);
        op_r(F_ADD, 2, 0, 0);                       // $0 must never be forwarded
        op_addi(3, 0, 16'hFFFF);
        op_sw(3, 0, 16'd20);
        op_lw(4, 0, 16'd20);
        op_r(F_ADD, 5, 4, 3);
        op_r(F_SUB, 6, 5, 0);
        op_r(F_AND, 7, 6, 3);
        op_r(F_OR, 8, 7, 0);
        op_r(F_SLT, 9, 3, 0);
        op_addi(10, 9, 16'd100);
        run_program("reg0_stall", 1'b1);
    endtask

    initial begin
        rst          = 1'b1;
        stall        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        dbg_mem_addr = '0;
        lfsr_q       = 16'd38;
        errors       = 0;
        checks       = 0;
        skip_count   = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            m_mem[i]   = '0;
            m_valid[i] = 1'b0;
        end
        clear_regs();
        test_arith();
        test_memory();
        test_branch();
        test_jump();
        test_reg0_stall();
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish within %0d cycles", WD_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- mips.f
+incdir+hw
hw/mips_pkg.sv
hw/mips_ifs.sv
hw/instruction_fetch.sv
hw/instruction_decode.sv
hw/execution.sv
hw/data_memory.sv
hw/mips.sv
sim/mips_tb.sv

//--- Bender.yml
package:
  name: mips

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_pkg.sv
      - hw/mips_ifs.sv
      - hw/instruction_fetch.sv
      - hw/instruction_decode.sv
      - hw/execution.sv
      - hw/data_memory.sv
      - hw/mips.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/mips_tb.sv
